// File: files.f
segPkg.sv
segFrameIf.sv
hexSegDecoder.sv
segFrameShifter.sv
segSerialCtrl.sv
segDisplayDriver.sv
segDisplayChecker.sv
segDisplayDriverTb.sv

// File: hexSegDecoder.sv
`timescale 1ns/100ps
`default_nettype none

// nibble, point and enable to an active-low segment byte for one digit
module hexSegDecoder (
    input  wire logic [3:0] nibble,
    input  wire logic point,  // 1 lights the point
    input  wire logic enableN,  // 1 blanks the digit
    output segPkg::segPattern seg
);

    logic [segPkg::segWidth-2:0] glyph;
    segPkg::segPattern litPattern;

    assign glyph = segPkg::hexToSeg(nibble);

    // active-high form with the point in the low bit
    assign litPattern = {glyph, point};

    always_comb begin
        if (enableN) begin
            seg = '1;  // all segments dark
        end else begin
            seg = ~litPattern;
        end
    end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# build and run the testbench, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module segDisplayDriverTb -f files.f -o segSim \
    && ./obj_dir/segSim | tee /dev/stderr | grep -qx "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: segDisplayChecker.sv
`timescale 1ns/100ps
`default_nettype none

// rebuilds each serial frame from the chain pins and compares it
module segDisplayChecker (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic finish,
    input  wire logic serialClk,
    input  wire logic serialData,
    input  wire logic [segPkg::frameWidth-1:0] expFrame,
    input  int testId,  // 0 until the first test is armed
    output int checkedCount,
    output int errorCount
);

    logic [segPkg::frameWidth-1:0] capFrame = '1;
    int edgeTotal = 0;
    int strayTotal = 0;  // serialClk edges seen while idle

    int edgeMark = 0;
    int strayMark = 0;
    int lastId = 0;
    logic prevFinish = 1'b1;

    initial begin
        checkedCount = 0;
        errorCount = 0;
    end

    // first bit in ends up in bit 0 as in the frame inside the DUT
    always @(posedge serialClk) begin
        if (finish) begin
            strayTotal <= strayTotal + 1;
        end else begin
            capFrame <= {serialData, capFrame[segPkg::frameWidth-1:1]};
            edgeTotal <= edgeTotal + 1;
        end
    end

    // finish only moves on rising clk, so the falling edge sees it settled
    always @(negedge clk) begin : frameEnd
        int edges;
        logic frameBad;
        if (reset) begin
            prevFinish = 1'b1;
        end else begin
            if (strayTotal != strayMark) begin
                $display("test %0d: serialClk rose while finish was high", testId);
                errorCount++;
                strayMark = strayTotal;
            end

            if (finish && !prevFinish) begin
                edges = edgeTotal - edgeMark;
                edgeMark = edgeTotal;
                frameBad = 1'b0;
                if (testId == lastId) begin
                    $display("an unexpected transfer ran after test %0d", testId);
                    errorCount++;
                end else begin
                    lastId = testId;
                    if (edges != segPkg::frameWidth) begin
                        $display("test %0d: saw %0d serialClk edges instead of %0d",
                            testId, edges, segPkg::frameWidth);
                        frameBad = 1'b1;
                    end
                    if (capFrame !== expFrame) begin
                        $display("mismatch serialFrame test %0d expected %016h actual %016h",
                            testId, expFrame, capFrame);
                        frameBad = 1'b1;
                    end
                    checkedCount++;
                    if (frameBad) begin
                        errorCount++;
                    end else begin
                        $display("test %0d ok, frame %016h", testId, capFrame);
                    end
                end
            end
            prevFinish = finish;
        end
    end

endmodule

`default_nettype wire

// File: segDisplayDriver.sv
`timescale 1ns/100ps
`default_nettype none

// drives eight hex digits through an external serial shift-register chain
module segDisplayDriver (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  wire logic [segPkg::digitCount-1:0] en,  // 0 lights the digit
    input  wire logic [4*segPkg::digitCount-1:0] num,
    input  wire logic [segPkg::digitCount-1:0] point,
    output wire logic finish,
    output wire logic serialClk,
    output wire logic serialData  // active low
);

    segFrameIf fr ();

    segPkg::segPattern digitSeg [segPkg::digitCount];

    for (genvar i = 0; i < segPkg::digitCount; i++) begin : gDigit
        hexSegDecoder decoder (
            .nibble  (num[4*i +: 4]),
            .point   (point[i]),
            .enableN (en[i]),
            .seg     (digitSeg[i])
        );

        // digit 0 sits in the top byte and leaves last
        assign fr.frame[segPkg::frameWidth-1-segPkg::segWidth*i -: segPkg::segWidth] =
            digitSeg[i];
    end

    segSerialCtrl ctrl (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .fr        (fr.ctrl),
        .finish    (finish),
        .serialClk (serialClk)
    );

    segFrameShifter shifter (
        .clk   (clk),
        .reset (reset),
        .fr    (fr.shifter)
    );

    assign serialData = fr.serialBit;

endmodule

`default_nettype wire

// File: segDisplayDriverTb.sv
`timescale 1ns/100ps
`default_nettype none

module segDisplayDriverTb;

    localparam int fixedCount = 6;
    localparam int randomCount = 6;
    localparam int testCount = fixedCount + randomCount;
    localparam int waitLimit = 200;  // cycles per wait
    localparam int idleCycles = 4;

    typedef struct packed {
        logic [31:0] num;
        logic [7:0] en;
        logic [7:0] point;
        logic extraStart;  // second start pulse and new inputs mid-shift
        logic [segPkg::frameWidth-1:0] frame;
    } stimEntry;

    logic clk;
    logic reset;
    logic start;
    logic [7:0] en;
    logic [31:0] num;
    logic [7:0] point;
    logic finish;
    logic serialClk;
    logic serialData;

    logic [segPkg::frameWidth-1:0] expFrame;
    int testId;
    int checkedCount;
    int errorCount;
    int benchErrors;
    stimEntry stim [testCount];

    segDisplayDriver u_dut (
        .clk(clk), .reset(reset), .start(start), .en(en), .num(num), .point(point),
        .finish(finish), .serialClk(serialClk), .serialData(serialData)
    );

    segDisplayChecker u_check (
        .clk(clk), .reset(reset), .finish(finish), .serialClk(serialClk),
        .serialData(serialData), .expFrame(expFrame), .testId(testId),
        .checkedCount(checkedCount), .errorCount(errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // digit 0 goes in first so it lands in the top byte
    function automatic logic [segPkg::frameWidth-1:0] buildFrame(
        input logic [31:0] n, input logic [7:0] e, input logic [7:0] p);
        logic [segPkg::frameWidth-1:0] f;
        logic [7:0] b;
        f = '0;
        for (int d = 0; d < segPkg::digitCount; d++) begin
            if (e[d]) b = 8'hff;
            else b = ~{segPkg::hexToSeg(n[4*d +: 4]), p[d]};
            f = {f[segPkg::frameWidth-segPkg::segWidth-1:0], b};
        end
        return f;
    endfunction

    task automatic fillTable();
        logic [31:0] seed;
        stim[0] = '{32'h76543210, 8'h00, 8'h00, 1'b0, '0};
        stim[1] = '{32'hfedcba98, 8'h00, 8'h00, 1'b0, '0};
        stim[2] = '{32'h01234567, 8'h00, 8'ha5, 1'b0, '0};  // points
        stim[3] = '{32'h89abcdef, 8'h3c, 8'hff, 1'b0, '0};  // middle digits dark
        stim[4] = '{32'h13579bdf, 8'hff, 8'h0f, 1'b0, '0};  // all dark
        stim[5] = '{32'h2468ace0, 8'h81, 8'h18, 1'b1, '0};
        seed = 32'h1aad;
        for (int i = fixedCount; i < testCount; i++) begin
            seed = xorshift32(seed);
            stim[i].num = seed;
            seed = xorshift32(seed);
            stim[i].en = seed[7:0] & seed[15:8];
            stim[i].point = seed[23:16];
            stim[i].extraStart = seed[31];
        end
        for (int i = 0; i < testCount; i++) begin
            stim[i].frame = buildFrame(stim[i].num, stim[i].en, stim[i].point);
        end
    endtask

    task automatic waitForFinish(input logic level, input string what, output logic late);
        int cycles;
        cycles = 0;
        late = 1'b0;
        while (finish !== level && !late) begin
            @(negedge clk);
            cycles++;
            if (cycles >= waitLimit && finish !== level) begin
                $display("timeout: finish did not %s within %0d cycles", what, waitLimit);
                late = 1'b1;
            end
        end
    endtask

    task automatic checkIdle(input int cycles, input string when);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (!finish) begin
                $display("finish went low %s", when);
                benchErrors++;
            end
        end
    endtask

    task automatic applyEntry(input int idx, output logic late);
        stimEntry s;
        s = stim[idx];
        @(posedge clk);
        #10;
        num = s.num;
        en = s.en;
        point = s.point;
        expFrame = s.frame;
        testId = idx + 1;
        @(posedge clk);
        #10 start = 1'b1;
        @(posedge clk);
        #10 start = 1'b0;
        waitForFinish(1'b0, "fall", late);
        if (!late && s.extraStart) begin
            repeat (5) @(posedge clk);
            #10;
            num = ~s.num;
            en = ~s.en;
            point = ~s.point;
            start = 1'b1;  // busy so it must be ignored
            @(posedge clk);
            #10 start = 1'b0;
        end
        if (!late) waitForFinish(1'b1, "rise", late);
        if (!late) checkIdle(idleCycles, "again without a new start");
    endtask

    initial begin
        logic timedOut;
        timedOut = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        num = '0;
        en = '0;
        point = '0;
        expFrame = '1;
        testId = 0;
        benchErrors = 0;
        fillTable();

        repeat (3) @(posedge clk);
        #10 reset = 1'b0;
        checkIdle(idleCycles, "directly after reset");

        for (int i = 0; i < testCount; i++) begin
            applyEntry(i, timedOut);
            if (timedOut) break;
        end

        if (!timedOut && checkedCount != testCount) begin
            $display("checker saw %0d transfers instead of %0d", checkedCount, testCount);
            benchErrors++;
        end
        $display("tests %0d, transfers checked %0d, checker errors %0d, bench errors %0d",
            testCount, checkedCount, errorCount, benchErrors);
        if (timedOut || errorCount != 0 || benchErrors != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: segFrameIf.sv
`timescale 1ns/100ps
`default_nettype none

// frame path between the decoder bank, controller and shift register
interface segFrameIf;

    logic [segPkg::frameWidth-1:0] frame;  // digit 0 in the top byte
    logic load;  // one-cycle capture strobe
    logic shift;  // high for the whole transfer
    logic serialBit;

    modport ctrl (
        output load,
        output shift
    );

    modport shifter (
        input  frame,
        input  load,
        input  shift,
        output serialBit
    );

    modport mon (
        input frame,
        input load,
        input shift,
        input serialBit
    );

endinterface

`default_nettype wire

// File: segFrameShifter.sv
`timescale 1ns/100ps
`default_nettype none

// parallel-load shift-right register whose bit 0 leaves first
module segFrameShifter (
    input wire logic clk,
    input wire logic reset,
    segFrameIf.shifter fr
);

    logic [segPkg::frameWidth-1:0] shiftReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            shiftReg <= '1;  // dark display
        end else if (fr.load) begin
            shiftReg <= fr.frame;
        end else if (fr.shift) begin
            // ones fill from the top so trailing bits read as segments off
            shiftReg <= {1'b1, shiftReg[segPkg::frameWidth-1:1]};
        end
    end

    assign fr.serialBit = shiftReg[0];

    // the controller must never reload in the middle of a transfer
    loadShiftExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(fr.load && fr.shift)
    );

endmodule

`default_nettype wire

// File: segPkg.sv
`default_nettype none

package segPkg;

    localparam int digitCount = 8;
    localparam int segWidth = 8;  // a..g plus point
    localparam int frameWidth = digitCount * segWidth;

    // one digit in active-high form with a in bit 7 and the point in bit 0
    typedef logic [segWidth-1:0] segPattern;

    // standard hex glyphs as {a, b, c, d, e, f, g}
    function automatic logic [segWidth-2:0] hexToSeg(input logic [3:0] nibble);
        logic [segWidth-2:0] glyph;
        case (nibble)
            4'h0: glyph = 7'h7e;
            4'h1: glyph = 7'h30;
            4'h2: glyph = 7'h6d;
            4'h3: glyph = 7'h79;
            4'h4: glyph = 7'h33;
            4'h5: glyph = 7'h5b;
            4'h6: glyph = 7'h5f;
            4'h7: glyph = 7'h70;
            4'h8: glyph = 7'h7f;
            4'h9: glyph = 7'h7b;
            4'ha: glyph = 7'h77;
            4'hb: glyph = 7'h1f;  // lower case b
            4'hc: glyph = 7'h4e;
            4'hd: glyph = 7'h3d;  // lower case d
            4'he: glyph = 7'h4f;
            default: glyph = 7'h47;  // F
        endcase
        return glyph;
    endfunction

endpackage

`default_nettype wire

// File: segSerialCtrl.sv
`timescale 1ns/100ps
`default_nettype none

// start edge, bit counter, shift window and serial clock
module segSerialCtrl (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,  // rising edge starts a transfer
    segFrameIf.ctrl fr,
    output wire logic finish,
    output wire logic serialClk
);

    logic prevStart;
    logic startEdge;
    logic idle;
    logic loadNow;
    logic [6:0] bitCount;  // bits still to go out
    logic shiftOn;

    always_ff @(posedge clk) begin
        if (reset) begin
            prevStart <= 1'b0;
        end else begin
            prevStart <= start;
        end
    end

    assign startEdge = start && !prevStart;

    // busy until the counter has drained and the last bit has gone
    assign idle = (bitCount == '0) && !shiftOn;
    assign loadNow = startEdge && idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            bitCount <= '0;
        end else if (loadNow) begin
            bitCount <= 7'(segPkg::frameWidth);
        end else if (bitCount != '0) begin
            bitCount <= bitCount - 7'd1;
        end
    end

    // trails the counter by one cycle, so 64 cycles per frame
    always_ff @(posedge clk) begin
        if (reset) begin
            shiftOn <= 1'b0;
        end else begin
            shiftOn <= (bitCount != '0);
        end
    end

    assign fr.load = loadNow;
    assign fr.shift = shiftOn;

    assign finish = !shiftOn;
    // rises at mid-cycle while serialData is stable
    assign serialClk = !clk && shiftOn;

    counterInRange: assert property (
        @(posedge clk) disable iff (reset)
        bitCount <= 7'(segPkg::frameWidth)
    );

    // finish still high on the edge after load, then low for the whole frame
    finishWindow: assert property (
        @(posedge clk) disable iff (reset)
        fr.load |=> finish ##1 (!finish) [* segPkg::frameWidth] ##1 finish
    );

endmodule

`default_nettype wire
